/* design/bridge_pkg.sv */
//****************************
// Shared widths, AHB and AXI encodings
// Strobe decode functions for write beats
//****************************

package bridge_pkg;

   localparam int addr_w = 32;
   localparam int data_w = 64;
   localparam int strb_w = data_w / 8;

   // AHB transfer type, only two codes are issued
   typedef enum logic [1:0] {
      htrans_idle   = 2'b00,
      htrans_nonseq = 2'b10
   } htrans_t;

   typedef enum logic [1:0] {
      resp_okay   = 2'b00,
      resp_slverr = 2'b10
   } axi_resp_t;

   typedef enum logic [2:0] {
      hsize_byte  = 3'd0,
      hsize_half  = 3'd1,
      hsize_word  = 3'd2,
      hsize_dword = 3'd3
   } hsize_t;

   //****************************
   // Strobe decode
   //****************************

   // Aligned pattern that fits one beat, narrow transfers always do
   function automatic logic strb_aligned(input logic [strb_w-1:0] strb, input hsize_t size);
      logic hit;
      case (strb)
         8'hff, 8'h0f, 8'hf0, 8'h03, 8'h0c, 8'h30, 8'hc0: hit = 1'b1;
         default: hit = 1'b0;
      endcase
      return hit || (size != hsize_dword);
   endfunction

   function automatic hsize_t strb_size(input logic [strb_w-1:0] strb);
      case (strb)
         8'hff:                      return hsize_dword;
         8'h0f, 8'hf0:               return hsize_word;
         8'h03, 8'h0c, 8'h30, 8'hc0: return hsize_half;
         default:                    return hsize_byte;
      endcase
   endfunction

   function automatic logic [2:0] strb_offset(input logic [strb_w-1:0] strb);
      case (strb)
         8'h0c:        return 3'd2;
         8'hf0, 8'h30: return 3'd4;
         8'hc0:        return 3'd6;
         default:      return 3'd0;   // ff, 0f and 03 start at lane 0
      endcase
   endfunction

   // Lowest set strobe at or above start, strb_w when none is left
   function automatic logic [3:0] next_strb_byte(input logic [strb_w-1:0] strb,
                                                 input logic [3:0] start);
      logic [3:0] idx;
      idx = 4'(strb_w);
      for (int i = strb_w - 1; i >= 0; i--) begin
         if (strb[i] && (4'(i) >= start))
            idx = 4'(i);
      end
      return idx;
   endfunction

endpackage

/* design/bridge_if.sv */
//****************************
// Command interface, accept stage to sequencer
// Response interface, sequencer to response buffer
//****************************

`timescale 1ns/1ps

interface bridge_cmd_if #(
   parameter int id_w = 1
);
   import bridge_pkg::*;

   logic                valid;
   logic                ready;
   logic                write;      // High for a buffered AXI write
   logic [id_w-1:0]     id;
   logic [addr_w-1:0]   addr;
   hsize_t              size;
   logic [strb_w-1:0]   strb;
   logic [data_w-1:0]   wdata;

   modport source (output valid, write, id, addr, size, strb, wdata, input ready);
   modport sink   (input valid, write, id, addr, size, strb, wdata, output ready);

endinterface

interface bridge_rsp_if #(
   parameter int id_w = 1
);
   import bridge_pkg::*;

   logic                valid;
   logic                ready;
   logic                write;      // Selects B or R channel
   logic                error;
   logic [id_w-1:0]     id;
   logic [data_w-1:0]   rdata;

   modport source (output valid, write, error, id, rdata, input ready);
   modport sink   (input valid, write, error, id, rdata, output ready);

endinterface

/* design/axi_cmd_accept.sv */
//****************************
// AXI AW, W and AR acceptance
// One-entry write buffer and command select
//****************************

`timescale 1ns/1ps

module axi_cmd_accept #(
   parameter int id_w = 1
) (
   input  logic                            bus_clk,
   input  logic                            rst,

   input  logic                            awvalid,
   output logic                            awready,
   input  logic [id_w-1:0]                 awid,
   input  logic [bridge_pkg::addr_w-1:0]   awaddr,

   input  logic                            wvalid,
   output logic                            wready,
   input  logic [bridge_pkg::data_w-1:0]   wdata,
   input  logic [bridge_pkg::strb_w-1:0]   wstrb,

   input  logic                            arvalid,
   output logic                            arready,
   input  logic [id_w-1:0]                 arid,
   input  logic [bridge_pkg::addr_w-1:0]   araddr,
   input  logic [2:0]                      arsize,

   bridge_cmd_if.source                    cmd
);
   import bridge_pkg::*;

   logic                aw_held;
   logic                w_held;
   logic [id_w-1:0]     aw_id;
   logic [addr_w-1:0]   aw_addr;
   logic [data_w-1:0]   w_data;
   logic [strb_w-1:0]   w_strb;
   logic                wr_full;
   logic                wr_sent;

   assign wr_full = aw_held & w_held;
   assign wr_sent = cmd.valid & cmd.ready & wr_full;

   assign awready = ~aw_held;
   assign wready  = ~w_held;
   assign arready = cmd.ready & ~wr_full;    // Complete write goes first

   //****************************
   // Write buffer halves
   //****************************
   always_ff @(posedge bus_clk) begin
      if (rst) begin
         aw_held <= 1'b0;
         w_held  <= 1'b0;
      end else begin
         if (awvalid && awready)
            aw_held <= 1'b1;
         else if (wr_sent)
            aw_held <= 1'b0;
         if (wvalid && wready)
            w_held <= 1'b1;
         else if (wr_sent)
            w_held <= 1'b0;
      end
   end

   always_ff @(posedge bus_clk) begin
      if (awvalid && awready) begin
         aw_id   <= awid;
         aw_addr <= awaddr;
      end
      if (wvalid && wready) begin
         w_data <= wdata;
         w_strb <= wstrb;
      end
   end

   // Read passes straight through when no write is waiting
   assign cmd.valid = wr_full | arvalid;
   assign cmd.write = wr_full;
   assign cmd.id    = wr_full ? aw_id : arid;
   assign cmd.addr  = wr_full ? aw_addr : araddr;
   assign cmd.size  = wr_full ? hsize_dword : hsize_t'(arsize);
   assign cmd.strb  = wr_full ? w_strb : {strb_w{1'b1}};
   assign cmd.wdata = w_data;

endmodule

/* design/ahb_beat_sequencer.sv */
//****************************
// Command to AHB-Lite beat FSM
// Byte splitting for unaligned strobes
// Response push with error address
//****************************

`timescale 1ns/1ps

module ahb_beat_sequencer #(
   parameter int id_w = 1
) (
   input  logic                            bus_clk,
   input  logic                            rst,

   bridge_cmd_if.sink                      cmd,
   bridge_rsp_if.source                    rsp,

   output logic [bridge_pkg::addr_w-1:0]   haddr,
   output bridge_pkg::htrans_t             htrans,
   output bridge_pkg::hsize_t              hsize,
   output logic                            hwrite,
   output logic [bridge_pkg::data_w-1:0]   hwdata,
   input  logic [bridge_pkg::data_w-1:0]   hrdata,
   input  logic                            hready,
   input  logic                            hresp
);
   import bridge_pkg::*;

   typedef enum logic [1:0] {
      st_idle,
      st_address,
      st_data,
      st_respond
   } state_t;

   state_t              state;

   // Registered command
   logic                c_write;
   logic [id_w-1:0]     c_id;
   logic [addr_w-1:0]   c_addr;
   hsize_t              c_size;
   logic [strb_w-1:0]   c_strb;
   logic [data_w-1:0]   c_wdata;
   logic                c_aligned;
   logic [2:0]          ptr;          // Current byte lane for split writes

   logic                r_error;
   logic [data_w-1:0]   r_rdata;

   logic                cmd_take;
   logic                take_aligned;
   logic [3:0]          first_ptr;
   logic [3:0]          next_ptr;
   logic                last_beat;
   logic [2:0]          beat_low;
   hsize_t              beat_size;
   logic [addr_w-1:0]   beat_addr;

   assign cmd.ready = (state == st_idle);
   assign cmd_take  = cmd.valid & cmd.ready;

   assign take_aligned = ~cmd.write | strb_aligned(cmd.strb, cmd.size);
   assign first_ptr    = next_strb_byte(cmd.strb, 4'd0);

   //****************************
   // Beat address and size
   //****************************
   always_comb begin
      if (!c_write) begin
         beat_low  = c_addr[2:0];
         beat_size = c_size;
      end else if (c_aligned) begin
         beat_low  = strb_offset(c_strb);
         beat_size = strb_size(c_strb);
      end else begin
         beat_low  = ptr;
         beat_size = hsize_byte;
      end
   end

   assign beat_addr = {c_addr[addr_w-1:3], beat_low};
   assign next_ptr  = next_strb_byte(c_strb, {1'b0, ptr} + 4'd1);
   assign last_beat = ~c_write | c_aligned | next_ptr[3];

   // FSM
   always_ff @(posedge bus_clk) begin
      if (rst) begin
         state <= st_idle;
      end else begin
         case (state)
            st_idle: begin
               if (cmd_take) begin
                  // A write with no strobes set needs no beat at all
                  if (!take_aligned && first_ptr[3])
                     state <= st_respond;
                  else
                     state <= st_address;
               end
            end
            st_address: state <= st_data;   // Prior beat already ended, one cycle here
            st_data: begin
               if (hready) begin
                  if (hresp || last_beat)
                     state <= st_respond;
                  else
                     state <= st_address;
               end
            end
            st_respond: begin
               if (rsp.ready)
                  state <= st_idle;
            end
            default: state <= st_idle;
         endcase
      end
   end

   // Command copy, byte pointer and response payload
   always_ff @(posedge bus_clk) begin
      if (cmd_take) begin
         c_write   <= cmd.write;
         c_id      <= cmd.id;
         c_addr    <= cmd.addr;
         c_size    <= cmd.size;
         c_strb    <= cmd.strb;
         c_wdata   <= cmd.wdata;
         c_aligned <= take_aligned;
         ptr       <= first_ptr[2:0];
         r_error   <= 1'b0;
      end
      if (state == st_data && hready) begin
         if (hresp) begin
            r_error <= 1'b1;
            r_rdata <= {2{beat_addr}};        // Failing beat address in both halves
         end else if (!c_write) begin
            r_rdata <= hrdata;
         end else if (!last_beat) begin
            ptr <= next_ptr[2:0];
         end
      end
   end

   //****************************
   // AHB and response outputs
   //****************************
   assign htrans = (state == st_address) ? htrans_nonseq : htrans_idle;
   assign haddr  = beat_addr;
   assign hsize  = beat_size;
   assign hwrite = c_write;
   assign hwdata = c_wdata;     // Byte beats use the lanes the strobes select

   assign rsp.valid = (state == st_respond);
   assign rsp.write = c_write;
   assign rsp.error = r_error;
   assign rsp.id    = c_id;
   assign rsp.rdata = r_rdata;

endmodule

/* design/axi_resp_buffer.sv */
//****************************
// One-entry response holder
// Drives AXI B and R channels
//****************************

`timescale 1ns/1ps

module axi_resp_buffer #(
   parameter int id_w = 1
) (
   input  logic                            bus_clk,
   input  logic                            rst,

   bridge_rsp_if.sink                      rsp,

   output logic                            bvalid,
   input  logic                            bready,
   output logic [id_w-1:0]                 bid,
   output bridge_pkg::axi_resp_t           bresp,

   output logic                            rvalid,
   input  logic                            rready,
   output logic [id_w-1:0]                 rid,
   output logic [bridge_pkg::data_w-1:0]   rdata,
   output bridge_pkg::axi_resp_t           rresp
);
   import bridge_pkg::*;

   logic                full;
   logic                h_write;
   logic                h_error;
   logic [id_w-1:0]     h_id;
   logic [data_w-1:0]   h_rdata;
   logic                pop;

   assign rsp.ready = ~full;
   assign pop       = (bvalid & bready) | (rvalid & rready);

   always_ff @(posedge bus_clk) begin
      if (rst)
         full <= 1'b0;
      else if (rsp.valid && rsp.ready)
         full <= 1'b1;
      else if (pop)
         full <= 1'b0;
   end

   always_ff @(posedge bus_clk) begin
      if (rsp.valid && rsp.ready) begin
         h_write <= rsp.write;
         h_error <= rsp.error;
         h_id    <= rsp.id;
         h_rdata <= rsp.rdata;
      end
   end

   assign bvalid = full & h_write;
   assign bid    = h_id;
   assign bresp  = h_error ? resp_slverr : resp_okay;

   assign rvalid = full & ~h_write;
   assign rid    = h_id;
   assign rdata  = h_rdata;
   assign rresp  = h_error ? resp_slverr : resp_okay;   // Same code on either channel

endmodule

/* design/axi_ahb_bridge.sv */
//****************************
// AXI4 to AHB-Lite bridge top
// Accept, sequence and respond stages
//****************************

`timescale 1ns/1ps

module axi_ahb_bridge #(
   parameter int id_w = 1
) (
   input  logic                            bus_clk,
   input  logic                            rst,

   // AXI write address and data
   input  logic                            awvalid,
   output logic                            awready,
   input  logic [id_w-1:0]                 awid,
   input  logic [bridge_pkg::addr_w-1:0]   awaddr,
   input  logic                            wvalid,
   output logic                            wready,
   input  logic [bridge_pkg::data_w-1:0]   wdata,
   input  logic [bridge_pkg::strb_w-1:0]   wstrb,

   output logic                            bvalid,
   input  logic                            bready,
   output logic [id_w-1:0]                 bid,
   output logic [1:0]                      bresp,

   // AXI read address and data
   input  logic                            arvalid,
   output logic                            arready,
   input  logic [id_w-1:0]                 arid,
   input  logic [bridge_pkg::addr_w-1:0]   araddr,
   input  logic [2:0]                      arsize,
   output logic                            rvalid,
   input  logic                            rready,
   output logic [id_w-1:0]                 rid,
   output logic [bridge_pkg::data_w-1:0]   rdata,
   output logic [1:0]                      rresp,
   output logic                            rlast,

   // AHB-Lite
   output logic [bridge_pkg::addr_w-1:0]   haddr,
   output logic [1:0]                      htrans,
   output logic [2:0]                      hsize,
   output logic                            hwrite,
   output logic [bridge_pkg::data_w-1:0]   hwdata,
   input  logic [bridge_pkg::data_w-1:0]   hrdata,
   input  logic                            hready,
   input  logic                            hresp
);

   bridge_cmd_if #(.id_w(id_w)) cmd_bus ();
   bridge_rsp_if #(.id_w(id_w)) rsp_bus ();

   assign rlast = 1'b1;   // Single-beat reads only

   axi_cmd_accept #(.id_w(id_w)) axi_cmd_accept_i (
      .bus_clk (bus_clk), .rst (rst),
      .awvalid (awvalid), .awready (awready), .awid (awid), .awaddr (awaddr),
      .wvalid  (wvalid),  .wready  (wready),  .wdata (wdata), .wstrb (wstrb),
      .arvalid (arvalid), .arready (arready), .arid (arid), .araddr (araddr),
      .arsize  (arsize),
      .cmd     (cmd_bus.source)
   );

   ahb_beat_sequencer #(.id_w(id_w)) ahb_beat_sequencer_i (
      .bus_clk (bus_clk), .rst (rst),
      .cmd     (cmd_bus.sink),
      .rsp     (rsp_bus.source),
      .haddr   (haddr),   .htrans (htrans), .hsize  (hsize),
      .hwrite  (hwrite),  .hwdata (hwdata), .hrdata (hrdata),
      .hready  (hready),  .hresp  (hresp)
   );

   axi_resp_buffer #(.id_w(id_w)) axi_resp_buffer_i (
      .bus_clk (bus_clk), .rst (rst),
      .rsp     (rsp_bus.sink),
      .bvalid  (bvalid), .bready (bready), .bid (bid), .bresp (bresp),
      .rvalid  (rvalid), .rready (rready), .rid (rid), .rdata (rdata),
      .rresp   (rresp)
   );

endmodule

/* sim/ahb_slave_model.sv */
//******************************
// AHB-Lite memory slave model
// Wait states, one error address, beat counter
//******************************

`timescale 1ns/1ps

module ahb_slave_model #(
   parameter logic [31:0] err_addr = 32'h0000_01f8
) (
   input  logic         bus_clk,
   input  logic         rst,
   input  logic [31:0]  haddr,
   input  logic [1:0]   htrans,
   input  logic [2:0]   hsize,
   input  logic         hwrite,
   input  logic [63:0]  hwdata,
   output logic [63:0]  hrdata,
   output logic         hready,
   output logic         hresp,
   input  logic [3:0]   wait_states,
   output logic [15:0]  beat_count
);

   logic [63:0]   mem [0:255];
   logic          busy;          // Data phase in progress
   logic          d_write;
   logic [31:0]   d_addr;
   logic [2:0]    d_size;
   logic [3:0]    wcnt;
   logic          d_err;

   assign d_err  = busy && (d_addr[31:3] == err_addr[31:3]);
   assign hready = !busy || (wcnt == 4'd0);
   assign hresp  = d_err && (wcnt == 4'd0);   // Error only on the last data cycle
   assign hrdata = mem[d_addr[10:3]];

   always @(posedge bus_clk) begin
      logic [63:0] w;
      if (rst) begin
         busy       <= 1'b0;
         wcnt       <= 4'd0;
         beat_count <= 16'd0;
         for (int i = 0; i < 256; i++)
            mem[i] <= {32'(i) * 32'h9e37_79b1, 32'h0bad_0000 | 32'(i << 3)};
      end else begin
         if (busy && wcnt != 4'd0)
            wcnt <= wcnt - 4'd1;
         if (busy && wcnt == 4'd0) begin
            busy <= 1'b0;
            w = mem[d_addr[10:3]];
            for (int i = 0; i < 8; i++) begin
               if (i >= int'(d_addr[2:0]) && i < int'(d_addr[2:0]) + (1 << d_size))
                  w[i*8 +: 8] = hwdata[i*8 +: 8];
            end
            if (d_write && !d_err)
               mem[d_addr[10:3]] <= w;
         end
         // New address phase
         if (htrans == 2'b10 && hready) begin
            busy       <= 1'b1;
            d_write    <= hwrite;
            d_addr     <= haddr;
            d_size     <= hsize;
            wcnt       <= wait_states;
            beat_count <= beat_count + 16'd1;
         end
      end
   end

endmodule

/* sim/ahb_bridge_assertions.sv */
//******************************
// AHB and AXI B channel protocol checks
// Bound into the bridge top
//******************************

`timescale 1ns/1ps

module ahb_bridge_assertions (
   input  logic                            bus_clk,
   input  logic                            rst,
   input  logic [bridge_pkg::addr_w-1:0]   haddr,
   input  logic [1:0]                      htrans,
   input  logic [2:0]                      hsize,
   input  logic                            bvalid,
   input  logic                            bready,
   input  logic [1:0]                      bresp
);

   // Beat address must match its size
   assert property (@(posedge bus_clk) disable iff (rst)
      htrans == 2'b10 |-> (haddr & ((32'd1 << hsize) - 32'd1)) == 32'd0)
      else $error("AHB beat address not aligned to hsize");

   assert property (@(posedge bus_clk) rst && $past(rst) |-> htrans == 2'b00)
      else $error("htrans not idle during reset");

   assert property (@(posedge bus_clk) disable iff (rst)
      bvalid && !bready |=> bvalid && $stable(bresp))
      else $error("bvalid dropped or bresp changed before bready");

endmodule

bind axi_ahb_bridge ahb_bridge_assertions ahb_bridge_assertions_i (
   .bus_clk (bus_clk), .rst (rst),
   .haddr   (haddr),   .htrans (htrans), .hsize (hsize),
   .bvalid  (bvalid),  .bready (bready), .bresp (bresp)
);

/* sim/tb_axi_ahb_bridge.sv */
//******************************
// Bridge testbench with AHB slave model
// Directed tests, LFSR data and stalls
//******************************

`timescale 1ns/1ps

module tb_axi_ahb_bridge;
   localparam int          id_w       = 4;
   localparam int          wait_limit = 400;
   localparam logic [31:0] err_addr   = 32'h0000_01f8;

   logic                bus_clk, rst;
   logic                awvalid, awready, wvalid, wready, bvalid, bready;
   logic                arvalid, arready, rvalid, rready, rlast;
   logic [id_w-1:0]     awid, bid, arid, rid;
   logic [31:0]         awaddr, araddr, haddr;
   logic [63:0]         wdata, rdata, hwdata, hrdata;
   logic [7:0]          wstrb;
   logic [2:0]          arsize, hsize;
   logic [1:0]          bresp, rresp, htrans;
   logic                hwrite, hready, hresp;
   logic [3:0]          wait_states;
   logic [15:0]         beat_count;
   logic [15:0]         lfsr;
   int                  err_count, timeout_count;

   axi_ahb_bridge #(.id_w(id_w)) axi_ahb_bridge_i (
      .bus_clk (bus_clk), .rst (rst),
      .awvalid (awvalid), .awready (awready), .awid (awid), .awaddr (awaddr),
      .wvalid  (wvalid),  .wready  (wready),  .wdata (wdata), .wstrb (wstrb),
      .bvalid  (bvalid),  .bready  (bready),  .bid (bid), .bresp (bresp),
      .arvalid (arvalid), .arready (arready), .arid (arid), .araddr (araddr),
      .arsize  (arsize),  .rvalid  (rvalid),  .rready (rready), .rid (rid),
      .rdata   (rdata),   .rresp   (rresp),   .rlast (rlast),
      .haddr   (haddr),   .htrans  (htrans),  .hsize (hsize), .hwrite (hwrite),
      .hwdata  (hwdata),  .hrdata  (hrdata),  .hready (hready), .hresp (hresp)
   );

   ahb_slave_model #(.err_addr(err_addr)) ahb_slave_model_i (
      .bus_clk (bus_clk), .rst (rst), .haddr (haddr), .htrans (htrans),
      .hsize   (hsize), .hwrite (hwrite), .hwdata (hwdata), .hrdata (hrdata),
      .hready  (hready), .hresp (hresp), .wait_states (wait_states),
      .beat_count (beat_count)
   );

   always #2 bus_clk = ~bus_clk;

   //******************************
   // Helpers
   //******************************
   function automatic logic [63:0] rand_bits(input int n);
      logic [63:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);   // Galois step
         v = {v[62:0], lfsr[0]};
      end
      return v;
   endfunction

   function automatic logic [63:0] merge_bytes(input logic [63:0] old, input logic [63:0] upd,
                                               input logic [7:0] strb);
      logic [63:0] m;
      for (int i = 0; i < 8; i++)
         m[i*8 +: 8] = strb[i] ? upd[i*8 +: 8] : old[i*8 +: 8];
      return m;
   endfunction

   task automatic check_value(input string name, input string what, input logic [63:0] exp,
                              input logic [63:0] act);
      assert (exp == act) else begin
         err_count++;
         $display("ERR %s %s: expected %h, actual %h", name, what, exp, act);
      end
   endtask

   task automatic flag_timeout(input string what);
      timeout_count++;
      $display("timeout: %s", what);
   endtask

   // Channel drivers, entered and left on a falling edge
   task automatic send_aw(input logic [id_w-1:0] id, input logic [31:0] addr);
      int t;
      t = 0;
      awvalid = 1'b1;
      awid    = id;
      awaddr  = addr;
      while (!awready && t < wait_limit) begin
         @(negedge bus_clk);
         t++;
      end
      if (!awready)
         flag_timeout("write address never accepted");
      @(negedge bus_clk);
      awvalid = 1'b0;
   endtask

   task automatic send_w(input logic [63:0] data, input logic [7:0] strb);
      int t;
      t = 0;
      wvalid = 1'b1;
      wdata  = data;
      wstrb  = strb;
      while (!wready && t < wait_limit) begin
         @(negedge bus_clk);
         t++;
      end
      if (!wready)
         flag_timeout("write data never accepted");
      @(negedge bus_clk);
      wvalid = 1'b0;
   endtask

   task automatic send_ar(input logic [id_w-1:0] id, input logic [31:0] addr);
      int t;
      t = 0;
      arvalid = 1'b1;
      arid    = id;
      araddr  = addr;
      arsize  = 3'd3;
      while (!arready && t < wait_limit) begin
         @(negedge bus_clk);
         t++;
      end
      if (!arready)
         flag_timeout("read address never accepted");
      @(negedge bus_clk);
      arvalid = 1'b0;
   endtask

   // Waits for B or R, holds ready low for stall cycles, then accepts
   task automatic take_response(input string name, input logic is_write,
                                input logic [id_w-1:0] exp_id, input logic [1:0] exp_resp,
                                input logic [63:0] exp_data, input int stall);
      int t;
      logic [id_w-1:0] id0;
      logic [1:0] resp0;
      logic [63:0] data0;
      logic last0;
      t = 0;
      while (!(is_write ? bvalid : rvalid) && t < wait_limit) begin
         @(negedge bus_clk);
         t++;
      end
      if (!(is_write ? bvalid : rvalid)) begin
         flag_timeout(is_write ? "no write response" : "no read response");
      end else begin
         id0   = is_write ? bid : rid;
         resp0 = is_write ? bresp : rresp;
         data0 = rdata;
         last0 = rlast;
         repeat (stall) begin
            @(negedge bus_clk);
            assert ((is_write ? bvalid : rvalid) && (is_write ? bid : rid) == id0 &&
                    (is_write ? bresp : rresp) == resp0 &&
                    (is_write || rdata == data0)) else begin
               err_count++;
               $display("%s: response dropped or changed while ready was low", name);
            end
         end
         bready = is_write;
         rready = !is_write;
         @(negedge bus_clk);
         bready = 1'b0;
         rready = 1'b0;
         check_value(name, "id", 64'(exp_id), 64'(id0));
         check_value(name, "resp", 64'(exp_resp), 64'(resp0));
         if (!is_write) begin
            check_value(name, "data", exp_data, data0);
            check_value(name, "rlast", 64'd1, 64'(last0));   // Single-beat reads
         end
         assert (!bvalid && !rvalid) else begin
            err_count++;
            $display("%s: response still valid after the handshake", name);
         end
      end
   endtask

   task automatic axi_write(input string name, input logic [id_w-1:0] id, input logic [31:0] addr,
                            input logic [63:0] data, input logic [7:0] strb, input logic w_first,
                            input logic [1:0] exp_resp, input int stall);
      if (w_first) begin
         send_w(data, strb);
         send_aw(id, addr);
      end else begin
         send_aw(id, addr);
         send_w(data, strb);
      end
      take_response(name, 1'b1, id, exp_resp, 64'd0, stall);
   endtask

   task automatic axi_read(input string name, input logic [id_w-1:0] id, input logic [31:0] addr,
                           input logic [1:0] exp_resp, input logic [63:0] exp_data,
                           input int stall);
      send_ar(id, addr);
      take_response(name, 1'b0, id, exp_resp, exp_data, stall);
   endtask

   //******************************
   // Directed tests
   //******************************
   task automatic test_full_write_read();
      logic [63:0] d;
      logic [15:0] b0;
      d  = rand_bits(64);
      b0 = beat_count;
      axi_write("full_write", 4'h3, 32'h0000_0100, d, 8'hff, 1'b0, 2'b00, 0);
      check_value("full_write", "beats", 64'd1, 64'(beat_count - b0));
      axi_read("full_read", 4'h5, 32'h0000_0100, 2'b00, d, 0);
   endtask

   task automatic test_partial_strobe(input string name, input logic [31:0] addr,
                                      input logic [7:0] strb, input logic [63:0] exp_beats);
      logic [63:0] base;
      logic [63:0] upd;
      logic [15:0] b0;
      base = rand_bits(64);
      upd  = rand_bits(64);
      axi_write(name, 4'h1, addr, base, 8'hff, 1'b0, 2'b00, 0);   // Known contents first
      b0 = beat_count;
      axi_write(name, 4'h2, addr, upd, strb, 1'b1, 2'b00, 0);
      check_value(name, "beats", exp_beats, 64'(beat_count - b0));
      axi_read(name, 4'h4, addr, 2'b00, merge_bytes(base, upd, strb), 0);
   endtask

   task automatic test_error_response();
      axi_read("error_read", 4'h6, err_addr, 2'b10, {2{err_addr}}, 0);
      axi_write("error_write", 4'h7, err_addr, rand_bits(64), 8'hff, 1'b0, 2'b10, 0);
   endtask

   task automatic test_backpressure_order();
      logic [63:0] d;
      logic [31:0] a;
      int stall;
      wait_states = 4'(rand_bits(2)) + 4'd1;
      for (int k = 0; k < 4; k++) begin
         a     = 32'h0000_0180 + 32'(k * 8);
         d     = rand_bits(64);
         stall = int'(rand_bits(3));
         axi_write("backpressure", 4'(k), a, d, 8'hff, k[0], 2'b00, stall);   // Odd k sends W first
         stall = int'(rand_bits(3));
         axi_read("backpressure", 4'(k + 8), a, 2'b00, d, stall);
      end
      wait_states = 4'd0;
   endtask

   initial begin
      bus_clk = 1'b0;
      lfsr = 16'd19520;
      err_count = 0;
      timeout_count = 0;
      rst = 1'b1;
      {awvalid, wvalid, bready, arvalid, rready} = '0;
      awid = '0;
      arid = '0;
      awaddr = '0;
      araddr = '0;
      arsize = 3'd3;
      wdata = '0;
      wstrb = '0;
      wait_states = 4'd0;
      repeat (8) @(posedge bus_clk);
      @(negedge bus_clk);
      rst = 1'b0;
      check_value("reset", "ready", 64'd7, 64'({awready, wready, arready}));
      check_value("reset", "valid and htrans", 64'd0, 64'({bvalid, rvalid, htrans}));
      test_full_write_read();
      test_partial_strobe("strobe_0c", 32'h0000_0108, 8'h0c, 64'd1);
      test_partial_strobe("strobe_5a", 32'h0000_0110, 8'h5a, 64'd4);
      test_error_response();
      test_backpressure_order();
      $display("errors: %0d, timeouts: %0d", err_count, timeout_count);
      if (err_count == 0 && timeout_count == 0)
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   end

endmodule

/* sim.f */
design/bridge_pkg.sv
design/bridge_if.sv
design/axi_cmd_accept.sv
design/ahb_beat_sequencer.sv
design/axi_resp_buffer.sv
design/axi_ahb_bridge.sv
sim/ahb_slave_model.sv
sim/ahb_bridge_assertions.sv
sim/tb_axi_ahb_bridge.sv

/* Makefile */
# Verilator build and run of the AXI4 to AHB-Lite bridge testbench

TOP = tb_axi_ahb_bridge

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module $(TOP) \
		-f sim.f -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf obj_dir
